// File: fcmp_pkg.sv
package fcmp_pkg;

   // ============================================================
   // Field widths
   // ============================================================

   // Common layout shared by both formats after widening
   localparam int EXP_W  = 11;
   localparam int MANT_W = 52;

   // Native single precision fields
   localparam int S_EXP_W  = 8;
   localparam int S_MANT_W = 23;

   // Integer register file index
   localparam int RD_W = 5;

   // ============================================================
   // Operation encodings
   // ============================================================

   // Compare type, code 3 is left unused and is never issued
   typedef enum logic [1:0] {
      CMP_LT = 2'd0,
      CMP_LE = 2'd1,
      CMP_EQ = 2'd2
   } fp_cmp_t;

   // Operand format
   typedef enum logic {
      FMT_S = 1'b0,
      FMT_D = 1'b1
   } fp_fmt_t;

   // ============================================================
   // Operand word, one 64-bit register read two ways
   // ============================================================

   // Double precision view
   typedef struct packed {
      logic              sign;
      logic [EXP_W-1:0]  exp;
      logic [MANT_W-1:0] mant;
   } fp_dbl_t;

   // Single precision view, value sits in the low half
   typedef struct packed {
      logic [31:0]         box;
      logic                sign;
      logic [S_EXP_W-1:0]  exp;
      logic [S_MANT_W-1:0] mant;
   } fp_sgl_t;

   typedef union packed {
      fp_dbl_t d;
      fp_sgl_t s;
   } fp_word_u;

endpackage

// File: fcmp_issue.sv
`timescale 1ns/1ps

module fcmp_issue (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          issue,
   input  logic [63:0]                   op_a,
   input  logic [63:0]                   op_b,
   input  fcmp_pkg::fp_fmt_t             fmt,
   input  fcmp_pkg::fp_cmp_t             cmp_type,
   input  logic [fcmp_pkg::RD_W-1:0]     rd,
   input  logic [63:0]                   pc,
   output logic                          s0_valid,
   output logic                          s0_sign_a,
   output logic [fcmp_pkg::EXP_W-1:0]    s0_exp_a,
   output logic [fcmp_pkg::MANT_W-1:0]   s0_mant_a,
   output logic                          s0_sign_b,
   output logic [fcmp_pkg::EXP_W-1:0]    s0_exp_b,
   output logic [fcmp_pkg::MANT_W-1:0]   s0_mant_b,
   output logic                          s0_raw_eq,
   output fcmp_pkg::fp_cmp_t             s0_cmp,
   output logic [fcmp_pkg::RD_W-1:0]     s0_rd,
   output logic [63:0]                   s0_pc
);

   // Field extraction per format
   function automatic logic widen_sign(input fcmp_pkg::fp_word_u w,
                                       input fcmp_pkg::fp_fmt_t f);
      return (f == fcmp_pkg::FMT_D) ? w.d.sign : w.s.sign;
   endfunction

   // Zero-extend a single exponent, keeps unsigned ordering
   function automatic logic [fcmp_pkg::EXP_W-1:0] widen_exp(input fcmp_pkg::fp_word_u w,
                                                           input fcmp_pkg::fp_fmt_t f);
      if (f == fcmp_pkg::FMT_D)
         return w.d.exp;
      return {{(fcmp_pkg::EXP_W - fcmp_pkg::S_EXP_W){1'b0}}, w.s.exp};
   endfunction

   // Left-align a single mantissa, zero fill below
   function automatic logic [fcmp_pkg::MANT_W-1:0] widen_mant(input fcmp_pkg::fp_word_u w,
                                                             input fcmp_pkg::fp_fmt_t f);
      if (f == fcmp_pkg::FMT_D)
         return w.d.mant;
      return {w.s.mant, {(fcmp_pkg::MANT_W - fcmp_pkg::S_MANT_W){1'b0}}};
   endfunction

   fcmp_pkg::fp_word_u w_a;
   fcmp_pkg::fp_word_u w_b;
   logic               raw_eq;
   logic               cmp_legal;

   assign w_a = op_a;
   assign w_b = op_b;

   // Single compares only its own 32 bits, box bits are ignored
   assign raw_eq = (fmt == fcmp_pkg::FMT_D) ? (op_a == op_b) : (op_a[31:0] == op_b[31:0]);

   assign cmp_legal = cmp_type inside {fcmp_pkg::CMP_LT, fcmp_pkg::CMP_LE, fcmp_pkg::CMP_EQ};

   // ============================================================
   // Stage 0 registers
   // ============================================================

   // Valid drops an issue with the unused compare code
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         s0_valid <= 1'b0;
      else
         s0_valid <= issue & cmp_legal;
   end

   // Payload only loads on issue
   always_ff @(posedge clk)
   begin
      if (issue)
      begin
         s0_sign_a <= widen_sign(w_a, fmt);
         s0_exp_a  <= widen_exp(w_a, fmt);
         s0_mant_a <= widen_mant(w_a, fmt);
         s0_sign_b <= widen_sign(w_b, fmt);
         s0_exp_b  <= widen_exp(w_b, fmt);
         s0_mant_b <= widen_mant(w_b, fmt);
         s0_raw_eq <= raw_eq;
         s0_cmp    <= cmp_type;
         s0_rd     <= rd;
         s0_pc     <= pc;
      end
   end

   // Strobe must be clean once out of reset
   a_issue_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(issue))
      else $error("issue is unknown");

endmodule

// File: fp_compare.sv
`timescale 1ns/1ps

module fp_compare #(
   parameter int D = 4
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          s0_valid,
   input  logic                          s0_sign_a,
   input  logic [fcmp_pkg::EXP_W-1:0]    s0_exp_a,
   input  logic [fcmp_pkg::MANT_W-1:0]   s0_mant_a,
   input  logic                          s0_sign_b,
   input  logic [fcmp_pkg::EXP_W-1:0]    s0_exp_b,
   input  logic [fcmp_pkg::MANT_W-1:0]   s0_mant_b,
   input  logic                          s0_raw_eq,
   input  fcmp_pkg::fp_cmp_t             s0_cmp,
   input  logic [fcmp_pkg::RD_W-1:0]     s0_rd,
   input  logic [63:0]                   s0_pc,
   output logic                          c_valid,
   output logic                          c_result,
   output logic [fcmp_pkg::RD_W-1:0]     c_rd,
   output logic [63:0]                   c_pc
);

   localparam int MAG_W = fcmp_pkg::EXP_W + fcmp_pkg::MANT_W;

   // Depth of zero would leave no register at all
   if (D < 1)
   begin : g_bad_depth
      $error("fp_compare depth D must be at least 1");
   end

   // ============================================================
   // Ordering terms
   // ============================================================

   logic [MAG_W-1:0] mag_a;
   logic [MAG_W-1:0] mag_b;
   logic             sign_lt;
   logic             sign_eq;
   logic             mag_lt;
   logic             mag_gt;
   logic             both_pos;
   logic             both_neg;
   logic             lt;
   logic             result;

   // Magnitude orders by exponent first, then mantissa
   assign mag_a = {s0_exp_a, s0_mant_a};
   assign mag_b = {s0_exp_b, s0_mant_b};

   // Differing signs decide on their own
   assign sign_lt = s0_sign_a & ~s0_sign_b;
   assign sign_eq = (s0_sign_a == s0_sign_b);

   assign mag_lt = (mag_a < mag_b);
   assign mag_gt = (mag_a > mag_b);

   assign both_pos = sign_eq & ~s0_sign_a;
   assign both_neg = sign_eq & s0_sign_a;

   // Negative pair reverses the magnitude test
   assign lt = sign_lt | (both_pos & mag_lt) | (both_neg & mag_gt);

   // Select by compare type
   always_comb
   begin
      result = 1'b0;
      case (s0_cmp)
         fcmp_pkg::CMP_LT:
         begin
            result = lt;
         end
         fcmp_pkg::CMP_LE:
         begin
            result = lt | s0_raw_eq;
         end
         fcmp_pkg::CMP_EQ:
         begin
            // Raw bit equality, so -0 and +0 differ
            result = s0_raw_eq;
         end
         default:
         begin
            result = 1'b0;
         end
      endcase
   end

   // ============================================================
   // Delay chain, D stages
   // ============================================================

   logic [D-1:0]                valid_q;
   logic [D-1:0]                result_q;
   logic [fcmp_pkg::RD_W-1:0]   rd_q [D];
   logic [63:0]                 pc_q [D];

   // Valid bits are the only control state
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q <= '0;
      end
      else
      begin
         valid_q[0] <= s0_valid;
         for (int i = 1; i < D; i++)
            valid_q[i] <= valid_q[i-1];
      end
   end

   // Payload shifts every cycle
   always_ff @(posedge clk)
   begin
      result_q[0] <= result;
      rd_q[0]     <= s0_rd;
      pc_q[0]     <= s0_pc;
      for (int i = 1; i < D; i++)
      begin
         result_q[i] <= result_q[i-1];
         rd_q[i]     <= rd_q[i-1];
         pc_q[i]     <= pc_q[i-1];
      end
   end

   // Last stage feeds writeback
   assign c_valid  = valid_q[D-1];
   assign c_result = result_q[D-1];
   assign c_rd     = rd_q[D-1];
   assign c_pc     = pc_q[D-1];

   // Issue side must have filtered the unused code
   a_cmp_legal: assert property (@(posedge clk) disable iff (!rst_n)
      s0_valid |-> (s0_cmp inside {fcmp_pkg::CMP_LT, fcmp_pkg::CMP_LE, fcmp_pkg::CMP_EQ}))
      else $error("valid stage 0 with illegal compare code %0d", s0_cmp);

endmodule

// File: fcmp_writeback.sv
`timescale 1ns/1ps

module fcmp_writeback (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        c_valid,
   input  logic                        c_result,
   input  logic [fcmp_pkg::RD_W-1:0]   c_rd,
   input  logic [63:0]                 c_pc,
   output logic                        wb_en,
   output logic [fcmp_pkg::RD_W-1:0]   wb_rd,
   output logic [63:0]                 wb_data,
   output logic [63:0]                 wb_pc
);

   logic rd_zero;
   logic wr_ok;

   // x0 is hardwired, never written
   assign rd_zero = (c_rd == '0);
   assign wr_ok   = c_valid & ~rd_zero;

   // ============================================================
   // Writeback register
   // ============================================================

   // One pulse per surviving result
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         wb_en <= 1'b0;
      else
         wb_en <= wr_ok;
   end

   // Result widened to an integer 0 or 1
   always_ff @(posedge clk)
   begin
      if (c_valid)
      begin
         wb_data <= {63'd0, c_result};
         wb_rd   <= c_rd;
         wb_pc   <= c_pc;
      end
   end

   // Integer file must only ever see 0 or 1
   a_wb_bool: assert property (@(posedge clk) disable iff (!rst_n)
      wb_en |-> (wb_data[63:1] == 63'd0))
      else $error("writeback data not boolean: %h", wb_data);

endmodule

// File: fcmp_unit.sv
`timescale 1ns/1ps

module fcmp_unit #(
   parameter int D = 4
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        issue,
   input  logic [63:0]                 op_a,
   input  logic [63:0]                 op_b,
   input  fcmp_pkg::fp_fmt_t           fmt,
   input  fcmp_pkg::fp_cmp_t           cmp_type,
   input  logic [fcmp_pkg::RD_W-1:0]   rd,
   input  logic [63:0]                 pc,
   output logic                        wb_en,
   output logic [fcmp_pkg::RD_W-1:0]   wb_rd,
   output logic [63:0]                 wb_data,
   output logic [63:0]                 wb_pc
);

   // ============================================================
   // Stage 0 bundle
   // ============================================================

   logic                          s0_valid;
   logic                          s0_sign_a;
   logic [fcmp_pkg::EXP_W-1:0]    s0_exp_a;
   logic [fcmp_pkg::MANT_W-1:0]   s0_mant_a;
   logic                          s0_sign_b;
   logic [fcmp_pkg::EXP_W-1:0]    s0_exp_b;
   logic [fcmp_pkg::MANT_W-1:0]   s0_mant_b;
   logic                          s0_raw_eq;
   fcmp_pkg::fp_cmp_t             s0_cmp;
   logic [fcmp_pkg::RD_W-1:0]     s0_rd;
   logic [63:0]                   s0_pc;

   // Compare pipeline output
   logic                          c_valid;
   logic                          c_result;
   logic [fcmp_pkg::RD_W-1:0]     c_rd;
   logic [63:0]                   c_pc;

   // Input side, one cycle
   fcmp_issue u_issue (
      .clk       (clk),
      .rst_n     (rst_n),
      .issue     (issue),
      .op_a      (op_a),
      .op_b      (op_b),
      .fmt       (fmt),
      .cmp_type  (cmp_type),
      .rd        (rd),
      .pc        (pc),
      .s0_valid  (s0_valid),
      .s0_sign_a (s0_sign_a),
      .s0_exp_a  (s0_exp_a),
      .s0_mant_a (s0_mant_a),
      .s0_sign_b (s0_sign_b),
      .s0_exp_b  (s0_exp_b),
      .s0_mant_b (s0_mant_b),
      .s0_raw_eq (s0_raw_eq),
      .s0_cmp    (s0_cmp),
      .s0_rd     (s0_rd),
      .s0_pc     (s0_pc)
   );

   // Compare, D cycles
   fp_compare #(
      .D (D)
   ) u_compare (
      .clk       (clk),
      .rst_n     (rst_n),
      .s0_valid  (s0_valid),
      .s0_sign_a (s0_sign_a),
      .s0_exp_a  (s0_exp_a),
      .s0_mant_a (s0_mant_a),
      .s0_sign_b (s0_sign_b),
      .s0_exp_b  (s0_exp_b),
      .s0_mant_b (s0_mant_b),
      .s0_raw_eq (s0_raw_eq),
      .s0_cmp    (s0_cmp),
      .s0_rd     (s0_rd),
      .s0_pc     (s0_pc),
      .c_valid   (c_valid),
      .c_result  (c_result),
      .c_rd      (c_rd),
      .c_pc      (c_pc)
   );

   // Output side, one cycle
   fcmp_writeback u_writeback (
      .clk      (clk),
      .rst_n    (rst_n),
      .c_valid  (c_valid),
      .c_result (c_result),
      .c_rd     (c_rd),
      .c_pc     (c_pc),
      .wb_en    (wb_en),
      .wb_rd    (wb_rd),
      .wb_data  (wb_data),
      .wb_pc    (wb_pc)
   );

endmodule

// File: fcmp_tb.sv
`timescale 1ns/1ps

module fcmp_tb;

   localparam int D       = 4;
   localparam int TIMEOUT = 200;
   localparam int N_RAND  = 24;

   logic                        clk;
   logic                        rst_n;
   logic                        issue;
   logic [63:0]                 op_a;
   logic [63:0]                 op_b;
   fcmp_pkg::fp_fmt_t           fmt;
   fcmp_pkg::fp_cmp_t           cmp_type;
   logic [fcmp_pkg::RD_W-1:0]   rd;
   logic [63:0]                 pc;
   logic                        wb_en;
   logic [fcmp_pkg::RD_W-1:0]   wb_rd;
   logic [63:0]                 wb_data;
   logic [63:0]                 wb_pc;

   // ============================================================
   // Stimulus table, one entry per row, expected result included
   // ============================================================

   logic [63:0]                 tbl_a [$];
   logic [63:0]                 tbl_b [$];
   fcmp_pkg::fp_fmt_t           tbl_fmt [$];
   logic [1:0]                  tbl_cmp [$];
   logic [fcmp_pkg::RD_W-1:0]   tbl_rd [$];
   logic [63:0]                 tbl_pc [$];
   logic                        tbl_exp [$];

   // Writebacks still outstanding, in issue order
   logic [fcmp_pkg::RD_W-1:0]   exp_rd [$];
   logic [63:0]                 exp_data [$];
   logic [63:0]                 exp_pc [$];

   fcmp_unit #(
      .D (D)
   ) DUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .issue    (issue),
      .op_a     (op_a),
      .op_b     (op_b),
      .fmt      (fmt),
      .cmp_type (cmp_type),
      .rd       (rd),
      .pc       (pc),
      .wb_en    (wb_en),
      .wb_rd    (wb_rd),
      .wb_data  (wb_data),
      .wb_pc    (wb_pc)
   );

   // 40 ns period
   initial clk = 1'b0;
   always #20 clk = ~clk;

   // Double operand from its fields
   function automatic logic [63:0] make_dbl(input logic s, input logic [10:0] e,
                                            input logic [51:0] m);
      fcmp_pkg::fp_word_u w;
      w.d.sign = s;
      w.d.exp  = e;
      w.d.mant = m;
      return w;
   endfunction

   // Single operand, box bits carry whatever the caller gives
   function automatic logic [63:0] make_sgl(input logic [31:0] box, input logic s,
                                            input logic [7:0] e, input logic [22:0] m);
      fcmp_pkg::fp_word_u w;
      w.s.box  = box;
      w.s.sign = s;
      w.s.exp  = e;
      w.s.mant = m;
      return w;
   endfunction

   // Reference model, sign-magnitude order and raw bit equality
   function automatic logic ref_compare(input logic [63:0] a, input logic [63:0] b,
                                        input fcmp_pkg::fp_fmt_t f, input logic [1:0] c);
      logic        sa;
      logic        sb;
      logic [62:0] ma;
      logic [62:0] mb;
      logic        lt;
      logic        eq;
      if (f == fcmp_pkg::FMT_D)
      begin
         sa = a[63];
         sb = b[63];
         ma = a[62:0];
         mb = b[62:0];
         eq = (a == b);
      end
      else
      begin
         sa = a[31];
         sb = b[31];
         ma = {32'd0, a[30:0]};
         mb = {32'd0, b[30:0]};
         eq = (a[31:0] == b[31:0]);
      end
      if (sa != sb)
         lt = sa;
      else if (!sa)
         lt = (ma < mb);
      else
         // Larger magnitude is smaller when both are negative
         lt = (ma > mb);
      if (c == 2'd0)
         return lt;
      else if (c == 2'd1)
         return lt | eq;
      return eq;
   endfunction

   task automatic add_row(input logic [63:0] a, input logic [63:0] b,
                          input fcmp_pkg::fp_fmt_t f, input logic [1:0] c,
                          input logic [fcmp_pkg::RD_W-1:0] r, input logic [63:0] p);
      tbl_a.push_back(a);
      tbl_b.push_back(b);
      tbl_fmt.push_back(f);
      tbl_cmp.push_back(c);
      tbl_rd.push_back(r);
      tbl_pc.push_back(p);
      tbl_exp.push_back(ref_compare(a, b, f, c));
   endtask

   // Put one row on the inputs and log what it should produce
   task automatic drive_row(input int i);
      issue    = 1'b1;
      op_a     = tbl_a[i];
      op_b     = tbl_b[i];
      fmt      = tbl_fmt[i];
      cmp_type = fcmp_pkg::fp_cmp_t'(tbl_cmp[i]);
      rd       = tbl_rd[i];
      pc       = tbl_pc[i];
      // Unused code and x0 never reach the register file
      if (tbl_cmp[i] != 2'd3 && tbl_rd[i] != '0)
      begin
         exp_rd.push_back(tbl_rd[i]);
         exp_data.push_back({63'd0, tbl_exp[i]});
         exp_pc.push_back(tbl_pc[i]);
      end
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("ERR %s got %h expected %h", name, got, exp);
         $display("TEST FAIL");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // Writeback monitor, outputs settle well before the falling edge
   always @(negedge clk)
   begin
      if (rst_n && wb_en)
      begin
         if (exp_rd.size() == 0)
         begin
            $display("Writeback to rd %0d arrived with no operation outstanding", wb_rd);
            $display("TEST FAIL");
            $fatal(1, "extra writeback");
         end
         else
         begin
            check_value("wb_rd", wb_rd, exp_rd.pop_front());
            check_value("wb_data", wb_data, exp_data.pop_front());
            check_value("wb_pc", wb_pc, exp_pc.pop_front());
         end
      end
   end

   initial
   begin
      int unsigned         rnd;
      logic [63:0]         ra;
      logic [63:0]         rb;
      fcmp_pkg::fp_fmt_t   rf;
      int                  cnt;
      logic                seen;

      rst_n    = 1'b0;
      issue    = 1'b0;
      op_a     = '0;
      op_b     = '0;
      fmt      = fcmp_pkg::FMT_D;
      cmp_type = fcmp_pkg::CMP_LT;
      rd       = '0;
      pc       = '0;
      void'($urandom(32'h8c3c81a1));

      // ============================================================
      // Directed rows
      // ============================================================

      // Row 0 also serves the idle latency measurement, 1.0 vs 2.0
      add_row(make_dbl(0, 11'd1023, 0), make_dbl(0, 11'd1024, 0), fcmp_pkg::FMT_D,
              fcmp_pkg::CMP_LT, 5'd1, 64'h1000);
      add_row(make_dbl(0, 11'd1023, 0), make_dbl(0, 11'd1024, 0), fcmp_pkg::FMT_D,
              fcmp_pkg::CMP_LE, 5'd2, 64'h1004);
      add_row(make_dbl(0, 11'd1023, 0), make_dbl(0, 11'd1024, 0), fcmp_pkg::FMT_D,
              fcmp_pkg::CMP_EQ, 5'd3, 64'h1008);
      // Signs differ
      add_row(make_dbl(1, 11'd1023, 0), make_dbl(0, 11'd1023, 0), fcmp_pkg::FMT_D,
              fcmp_pkg::CMP_LT, 5'd4, 64'h100c);
      add_row(make_dbl(0, 11'd1023, 0), make_dbl(1, 11'd1023, 0), fcmp_pkg::FMT_D,
              fcmp_pkg::CMP_LT, 5'd5, 64'h1010);
      // Both negative, -2.0 below -1.0
      add_row(make_dbl(1, 11'd1024, 0), make_dbl(1, 11'd1023, 0), fcmp_pkg::FMT_D,
              fcmp_pkg::CMP_LT, 5'd6, 64'h1014);
      add_row(make_dbl(1, 11'd1023, 0), make_dbl(1, 11'd1024, 0), fcmp_pkg::FMT_D,
              fcmp_pkg::CMP_LE, 5'd7, 64'h1018);
      // Same exponent, mantissa decides, 1.5 vs 1.25
      add_row(make_dbl(0, 11'd1023, 52'h8_0000_0000_0000), make_dbl(0, 11'd1023,
              52'h4_0000_0000_0000), fcmp_pkg::FMT_D, fcmp_pkg::CMP_LT, 5'd8, 64'h101c);
      add_row(make_dbl(1, 11'd1023, 52'h8_0000_0000_0000), make_dbl(1, 11'd1023,
              52'h4_0000_0000_0000), fcmp_pkg::FMT_D, fcmp_pkg::CMP_LT, 5'd9, 64'h1020);
      // Exact equality under all three types
      add_row(64'h3ff8_0000_0000_0000, 64'h3ff8_0000_0000_0000, fcmp_pkg::FMT_D,
              fcmp_pkg::CMP_EQ, 5'd10, 64'h1024);
      add_row(64'h3ff8_0000_0000_0000, 64'h3ff8_0000_0000_0000, fcmp_pkg::FMT_D,
              fcmp_pkg::CMP_LE, 5'd11, 64'h1028);
      add_row(64'h3ff8_0000_0000_0000, 64'h3ff8_0000_0000_0000, fcmp_pkg::FMT_D,
              fcmp_pkg::CMP_LT, 5'd12, 64'h102c);
      // -0 vs +0 double
      add_row(make_dbl(1, 0, 0), make_dbl(0, 0, 0), fcmp_pkg::FMT_D,
              fcmp_pkg::CMP_LT, 5'd13, 64'h1030);
      add_row(make_dbl(1, 0, 0), make_dbl(0, 0, 0), fcmp_pkg::FMT_D,
              fcmp_pkg::CMP_EQ, 5'd14, 64'h1034);
      // Single with random box bits
      add_row(make_sgl($urandom, 0, 8'd127, 0), make_sgl($urandom, 0, 8'd128, 0),
              fcmp_pkg::FMT_S, fcmp_pkg::CMP_LT, 5'd15, 64'h1038);
      add_row(make_sgl($urandom, 1, 8'd128, 23'h40_0000), make_sgl($urandom, 1, 8'd128, 0),
              fcmp_pkg::FMT_S, fcmp_pkg::CMP_LT, 5'd16, 64'h103c);
      add_row(make_sgl($urandom, 0, 8'd130, 23'h12_3456), make_sgl($urandom, 0, 8'd130,
              23'h12_3456), fcmp_pkg::FMT_S, fcmp_pkg::CMP_EQ, 5'd17, 64'h1040);
      add_row(make_sgl($urandom, 1, 0, 0), make_sgl($urandom, 0, 0, 0),
              fcmp_pkg::FMT_S, fcmp_pkg::CMP_LT, 5'd18, 64'h1044);
      add_row(make_sgl($urandom, 1, 0, 0), make_sgl($urandom, 0, 0, 0),
              fcmp_pkg::FMT_S, fcmp_pkg::CMP_EQ, 5'd19, 64'h1048);
      add_row(make_sgl($urandom, 1, 0, 0), make_sgl($urandom, 0, 0, 0),
              fcmp_pkg::FMT_S, fcmp_pkg::CMP_LE, 5'd20, 64'h104c);
      // Dropped, unused code then x0
      add_row(64'h1, 64'h2, fcmp_pkg::FMT_D, 2'd3, 5'd21, 64'h1050);
      add_row(64'h1, 64'h2, fcmp_pkg::FMT_D, fcmp_pkg::CMP_LT, 5'd0, 64'h1054);

      // Random rows, some share operand bits to hit equality
      for (int k = 0; k < N_RAND; k++)
      begin
         ra  = {$urandom, $urandom};
         rf  = fcmp_pkg::fp_fmt_t'($urandom_range(1));
         rb  = {$urandom, $urandom};
         if ($urandom_range(3) == 0)
            rb = (rf == fcmp_pkg::FMT_D) ? ra : {$urandom, ra[31:0]};
         rnd = $urandom;
         add_row(ra, rb, rf, 2'($urandom_range(2)), rnd[fcmp_pkg::RD_W-1:0],
                 64'h8000_0000 + 64'(4 * k));
      end

      // ============================================================
      // Reset, latency, then the table back to back
      // ============================================================

      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      @(posedge clk);
      #2;

      // Edge count starts with the edge that samples the issue
      drive_row(0);
      cnt  = 0;
      seen = 1'b0;
      while (!seen && cnt < TIMEOUT)
      begin
         @(posedge clk);
         #2;
         issue = 1'b0;
         cnt++;
         seen = wb_en;
      end
      if (!seen)
      begin
         $display("Writeback for the latency row never arrived");
         $display("TEST FAIL");
         $fatal(1, "timeout");
      end
      else
      begin
         check_value("latency", cnt, D + 2);
      end

      // One row per cycle
      for (int i = 1; i < tbl_a.size(); i++)
      begin
         drive_row(i);
         @(posedge clk);
         #2;
      end
      issue = 1'b0;

      cnt = 0;
      while (exp_rd.size() != 0 && cnt < TIMEOUT)
      begin
         @(posedge clk);
         cnt++;
      end
      // Extra cycles so a stray pulse still shows up
      repeat (D + 4) @(posedge clk);

      if (exp_rd.size() != 0)
      begin
         $display("Writeback never arrived for %0d operations", exp_rd.size());
         $display("TEST FAIL");
         $fatal(1, "timeout");
      end
      else
      begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

// File: fcmp_unit.f
fcmp_pkg.sv
fcmp_issue.sv
fp_compare.sv
fcmp_writeback.sv
fcmp_unit.sv
fcmp_tb.sv

// File: Bender.yml
package:
  name: fcmp_unit

sources:
  - fcmp_pkg.sv
  - fcmp_issue.sv
  - fp_compare.sv
  - fcmp_writeback.sv
  - fcmp_unit.sv
  - target: test
    files:
      - fcmp_tb.sv
